// File: compile.f
mem_pkg.sv
mem_bus_if.sv
wb_stage_if.sv
store_align.sv
mem_access_stage.sv
data_bus_unit.sv
load_extract_stage.sv
mem_stage_top.sv
tb_data_mem.sv
tb_mem_stage.sv

// File: tb_mem_stage.sv
`timescale 1ns/10ps

module tb_mem_stage import mem_pkg::*; ();

    localparam int TAG_W      = 4;
    localparam int CLK_PERIOD = 4;
    localparam int MAX_UOPS   = 400;
    localparam int UOP_CYCLES = 20;
    localparam int N_RANDOM   = 250;

    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [REG_ADDR_W-1:0] rd;
        logic [DATA_W-1:0]     data;
        logic                  dchk;    // data compared, not for aligned stores
        logic                  we;
        logic                  fault;
    } wb_exp_t;

    logic                  clk = 1'b0;
    logic                  rstn;
    logic                  uop_valid;
    logic [TAG_W-1:0]      uop_tag;
    logic [REG_ADDR_W-1:0] uop_rd;
    mem_op_e               uop_op;
    logic [DATA_W-1:0]     uop_word;
    logic [DATA_W-1:0]     uop_wdata;
    logic                  stall;
    logic                  wb_valid;
    logic [TAG_W-1:0]      wb_tag;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [DATA_W-1:0]     wb_data;
    logic                  wb_we;
    logic                  wb_fault;
    logic                  dmem_req;
    logic                  dmem_we;
    logic [ADDR_W-1:0]     dmem_addr;
    logic [BE_W-1:0]       dmem_be;
    logic [DATA_W-1:0]     dmem_wdata;
    logic                  dmem_ack;
    logic [DATA_W-1:0]     dmem_rdata;

    logic [DATA_W-1:0]     shadow [0:255];
    wb_exp_t               exp_q  [0:MAX_UOPS-1];
    wb_exp_t               head;
    int                    wr_ptr = 0;
    int                    rd_ptr = 0;
    int                    n_sent = 0;
    int                    exp_xfers = 0;
    int                    seen_xfers = 0;
    logic                  started = 1'b0;
    logic                  req_q;
    logic                  x_we;
    logic [ADDR_W-1:0]     x_addr;
    logic [BE_W-1:0]       x_be;
    logic [DATA_W-1:0]     x_wdata;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mem_stage_top #(.TAG_W(TAG_W)) dut (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .uop_valid_i   (uop_valid),
        .uop_tag_i     (uop_tag),
        .uop_rd_addr_i (uop_rd),
        .uop_op_i      (uop_op),
        .uop_word_i    (uop_word),
        .uop_wdata_i   (uop_wdata),
        .stall_o       (stall),
        .wb_valid_o    (wb_valid),
        .wb_tag_o      (wb_tag),
        .wb_rd_addr_o  (wb_rd),
        .wb_data_o     (wb_data),
        .wb_we_o       (wb_we),
        .wb_fault_o    (wb_fault),
        .dmem_req_o    (dmem_req),
        .dmem_we_o     (dmem_we),
        .dmem_addr_o   (dmem_addr),
        .dmem_be_o     (dmem_be),
        .dmem_wdata_o  (dmem_wdata),
        .dmem_ack_i    (dmem_ack),
        .dmem_rdata_i  (dmem_rdata)
    );

    tb_data_mem u_mem (
        .clk_i   (clk),
        .req_i   (dmem_req),
        .we_i    (dmem_we),
        .addr_i  (dmem_addr),
        .be_i    (dmem_be),
        .wdata_i (dmem_wdata),
        .ack_o   (dmem_ack),
        .rdata_o (dmem_rdata)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    function automatic logic [DATA_W-1:0] byte_addr(input int idx, input int off);
        return {22'h0, idx[7:0], off[1:0]};
    endfunction

    function automatic logic is_misaligned(input mem_op_e op, input logic [1:0] off);
        case (op)
            MEM_LH, MEM_LHU, MEM_SH: return off[0];
            MEM_LW, MEM_SW:          return off != 2'b00;
            default:                 return 1'b0;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] load_value(input mem_op_e op,
                                                     input logic [DATA_W-1:0] w,
                                                     input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'h0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'h0, h};
            default: return w;
        endcase
    endfunction

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic send_uop(input mem_op_e op, input logic [DATA_W-1:0] word,
                            input logic [DATA_W-1:0] wdata);
        wb_exp_t    e;
        logic [7:0] idx;
        logic [1:0] off;
        logic       st;
        logic       bad;
        idx = word[9:2];
        off = word[1:0];
        st  = op inside {MEM_SB, MEM_SH, MEM_SW};
        bad = is_misaligned(op, off);
        uop_valid = 1'b1;
        uop_tag   = n_sent[TAG_W-1:0];
        uop_rd    = $urandom_range(31, 0);
        uop_op    = op;
        uop_word  = word;
        uop_wdata = wdata;
        while (stall) begin
            @(posedge clk);
            #1;
        end
        started  = 1'b1;
        e.tag    = uop_tag;
        e.rd     = uop_rd;
        e.fault  = bad;
        e.we     = !bad && !st;
        e.dchk   = !st || bad;
        e.data   = bad ? '0 : (op == MEM_NONE ? word : load_value(op, shadow[idx], off));
        if (op != MEM_NONE && !bad) begin
            exp_xfers++;
            x_we    = st;
            x_addr  = word[31:2];
            x_be    = 4'hf;
            x_wdata = wdata;
            if (op == MEM_SB) begin
                x_be    = 4'b0001 << off;
                x_wdata = {4{wdata[7:0]}};
            end else if (op == MEM_SH) begin
                x_be    = off[1] ? 4'b1100 : 4'b0011;
                x_wdata = {2{wdata[15:0]}};
            end
            for (int b = 0; b < BE_W; b++) begin
                if (st && x_be[b]) begin
                    shadow[idx][8*b +: 8] = x_wdata[8*b +: 8];
                end
            end
        end
        exp_q[wr_ptr] = e;
        wr_ptr++;
        n_sent++;
        @(posedge clk);
        #1;
        uop_valid = 1'b0;
    endtask

    assign head = exp_q[rd_ptr];

    always @(posedge clk) begin
        req_q <= dmem_req;
        if (wb_valid) begin
            rd_ptr <= rd_ptr + 1;
        end
        if (dmem_req && !req_q) begin
            seen_xfers <= seen_xfers + 1;
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rstn)
        !started |-> !dmem_req && !stall && !wb_valid)
        else stop_with_error($sformatf("[ERROR] dmem_req_o/stall_o/wb_valid_o %h/%h/%h idle",
            $sampled(dmem_req), $sampled(stall), $sampled(wb_valid)));

    a_wb_expected: assert property (@(posedge clk) disable iff (!rstn)
        wb_valid |-> rd_ptr < wr_ptr)
        else stop_with_error("writeback appeared with no micro-op outstanding");

    a_wb_id: assert property (@(posedge clk) disable iff (!rstn)
        wb_valid |-> wb_tag == head.tag && wb_rd == head.rd)
        else stop_with_error($sformatf("[ERROR] wb_tag_o/wb_rd_addr_o %h/%h expected %h/%h",
            $sampled(wb_tag), $sampled(wb_rd), $sampled(head.tag), $sampled(head.rd)));

    a_wb_flags: assert property (@(posedge clk) disable iff (!rstn)
        wb_valid |-> wb_we == head.we && wb_fault == head.fault)
        else stop_with_error($sformatf("[ERROR] wb_we_o/wb_fault_o %h/%h expected %h/%h",
            $sampled(wb_we), $sampled(wb_fault), $sampled(head.we), $sampled(head.fault)));

    a_wb_data: assert property (@(posedge clk) disable iff (!rstn)
        wb_valid && head.dchk |-> wb_data == head.data)
        else stop_with_error($sformatf("[ERROR] wb_data_o %h expected %h",
            $sampled(wb_data), $sampled(head.data)));

    // only one memory op is ever open
    a_one_xfer: assert property (@(posedge clk) disable iff (!rstn)
        $rose(dmem_req) |-> seen_xfers == exp_xfers - 1)
        else stop_with_error("data memory transfer started with no aligned memory op open");

    a_xfer_addr: assert property (@(posedge clk) disable iff (!rstn)
        $rose(dmem_req) |-> dmem_we == x_we && dmem_addr == x_addr)
        else stop_with_error($sformatf("[ERROR] dmem_we_o/dmem_addr_o %h/%h expected %h/%h",
            $sampled(dmem_we), $sampled(dmem_addr), x_we, x_addr));

    a_xfer_lanes: assert property (@(posedge clk) disable iff (!rstn)
        $rose(dmem_req) |-> dmem_be == x_be && (!x_we || dmem_wdata == x_wdata))
        else stop_with_error($sformatf("[ERROR] dmem_be_o/dmem_wdata_o %h/%h expected %h/%h",
            $sampled(dmem_be), $sampled(dmem_wdata), x_be, x_wdata));

    a_req_until_ack: assert property (@(posedge clk) disable iff (!rstn)
        dmem_req && !dmem_ack |=> dmem_req)
        else stop_with_error("dmem_req_o dropped before dmem_ack_i arrived");

    a_no_req_on_ack: assert property (@(posedge clk) disable iff (!rstn)
        !dmem_req && dmem_ack |=> !dmem_req)
        else stop_with_error("dmem_req_o rose while dmem_ack_i was still high");

    a_stall_in_xfer: assert property (@(posedge clk) disable iff (!rstn)
        dmem_req || dmem_ack |-> stall)
        else stop_with_error("stall_o low during an open data memory transfer");

    initial begin
        #(MAX_UOPS * UOP_CYCLES * CLK_PERIOD);
        stop_with_error("watchdog expired before all micro-ops were written back");
    end

    initial begin
        logic [7:0] a;
        void'($urandom(32'h574b));
        for (int i = 0; i < 256; i++) begin
            a = i[7:0];
            shadow[i] = {a, ~a, a ^ 8'h5a, a + 8'h31};    // same fill as the memory model
        end
        rstn      = 1'b0;
        uop_valid = 1'b0;
        uop_tag   = '0;
        uop_rd    = '0;
        uop_op    = MEM_NONE;
        uop_word  = '0;
        uop_wdata = '0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        repeat (5) begin
            @(posedge clk);
            #1;
        end
        repeat (16) send_uop(MEM_NONE, $urandom, $urandom);
        // word store, then every load kind at every legal offset
        for (int i = 0; i < 4; i++) begin
            send_uop(MEM_SW, byte_addr(i * 7 + 3, 0), $urandom);
            for (int off = 0; off < 4; off++) begin
                send_uop(MEM_LB, byte_addr(i * 7 + 3, off), '0);
                send_uop(MEM_LBU, byte_addr(i * 7 + 3, off), '0);
                if (off % 2 == 0) begin
                    send_uop(MEM_LH, byte_addr(i * 7 + 3, off), '0);
                    send_uop(MEM_LHU, byte_addr(i * 7 + 3, off), '0);
                end
            end
            send_uop(MEM_LW, byte_addr(i * 7 + 3, 0), '0);
        end
        // partial stores into fill words
        for (int i = 0; i < 4; i++) begin
            for (int off = 0; off < 4; off++) begin
                send_uop(MEM_SB, byte_addr(i * 11 + 100, off), $urandom);
            end
            send_uop(MEM_LW, byte_addr(i * 11 + 100, 0), '0);
            send_uop(MEM_SH, byte_addr(i * 11 + 101, 0), $urandom);
            send_uop(MEM_SH, byte_addr(i * 11 + 101, 2), $urandom);
            send_uop(MEM_LW, byte_addr(i * 11 + 101, 0), '0);
        end
        for (int off = 1; off < 4; off++) begin
            send_uop(MEM_LW, byte_addr(9, off), '0);
            send_uop(MEM_SW, byte_addr(9, off), $urandom);
            if (off != 2) begin
                send_uop(MEM_LH, byte_addr(9, off), '0);
                send_uop(MEM_LHU, byte_addr(9, off), '0);
                send_uop(MEM_SH, byte_addr(9, off), $urandom);
            end
        end
        repeat (N_RANDOM) begin
            send_uop(mem_op_e'($urandom_range(8, 0)),
                     byte_addr($urandom_range(255, 0), $urandom_range(3, 0)), $urandom);
        end
        while (rd_ptr != wr_ptr) begin
            @(posedge clk);
            #1;
        end
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        if (seen_xfers != exp_xfers || rd_ptr != wr_ptr) begin
            stop_with_error($sformatf("%0d transfers seen for %0d aligned memory ops",
                seen_xfers, exp_xfers));
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: tb_data_mem.sv
`timescale 1ns/10ps

module tb_data_mem import mem_pkg::*; (
    input  logic              clk_i,
    input  logic              req_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [BE_W-1:0]   be_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic              ack_o,
    output logic [DATA_W-1:0] rdata_o
);

    logic [DATA_W-1:0] mem [0:255];
    int                wait_cycles;

    function automatic logic [DATA_W-1:0] fill_word(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {a, ~a, a ^ 8'h5a, a + 8'h31};
    endfunction

    initial begin
        ack_o   = 1'b0;
        rdata_o = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
    end

    // one four-phase transfer per pass, all changes 1 ns after the edge
    always begin
        @(posedge clk_i);
        #1;
        if (req_i === 1'b1 && !ack_o) begin
            wait_cycles = $urandom_range(5, 0);
            repeat (wait_cycles) begin
                @(posedge clk_i);
                #1;
            end
            if (we_i) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (be_i[b]) begin
                        mem[addr_i[7:0]][8*b +: 8] = wdata_i[8*b +: 8];
                    end
                end
            end
            rdata_o = mem[addr_i[7:0]];
            ack_o   = 1'b1;
            while (req_i) begin
                @(posedge clk_i);
                #1;
            end
            wait_cycles = $urandom_range(3, 0);    // late ack release
            repeat (wait_cycles) begin
                @(posedge clk_i);
                #1;
            end
            ack_o = 1'b0;
        end
    end

endmodule

// File: mem_stage_top.sv
`timescale 1ns/10ps

module mem_stage_top import mem_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    // from execute
    input  logic                  uop_valid_i,
    input  logic [TAG_W-1:0]      uop_tag_i,
    input  logic [REG_ADDR_W-1:0] uop_rd_addr_i,
    input  mem_op_e               uop_op_i,
    input  logic [DATA_W-1:0]     uop_word_i,
    input  logic [DATA_W-1:0]     uop_wdata_i,
    output logic                  stall_o,
    // writeback
    output logic                  wb_valid_o,
    output logic [TAG_W-1:0]      wb_tag_o,
    output logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic [DATA_W-1:0]     wb_data_o,
    output logic                  wb_we_o,
    output logic                  wb_fault_o,
    // data memory, four-phase
    output logic                  dmem_req_o,
    output logic                  dmem_we_o,
    output logic [ADDR_W-1:0]     dmem_addr_o,
    output logic [BE_W-1:0]       dmem_be_o,
    output logic [DATA_W-1:0]     dmem_wdata_o,
    input  logic                  dmem_ack_i,
    input  logic [DATA_W-1:0]     dmem_rdata_i
);

    mem_bus_if                   bus_if ();
    wb_stage_if #(.TAG_W(TAG_W)) wb_if ();

    mem_access_stage #(.TAG_W(TAG_W)) u_access (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .uop_valid_i   (uop_valid_i),
        .uop_tag_i     (uop_tag_i),
        .uop_rd_addr_i (uop_rd_addr_i),
        .uop_op_i      (uop_op_i),
        .uop_word_i    (uop_word_i),
        .uop_wdata_i   (uop_wdata_i),
        .stall_o       (stall_o),
        .bus           (bus_if.requester),
        .wb            (wb_if.source)
    );

    data_bus_unit u_bus (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .bus          (bus_if.completer),
        .dmem_req_o   (dmem_req_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_be_o    (dmem_be_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_ack_i   (dmem_ack_i),
        .dmem_rdata_i (dmem_rdata_i)
    );

    load_extract_stage #(.TAG_W(TAG_W)) u_extract (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .wb           (wb_if.sink),
        .wb_valid_o   (wb_valid_o),
        .wb_tag_o     (wb_tag_o),
        .wb_rd_addr_o (wb_rd_addr_o),
        .wb_data_o    (wb_data_o),
        .wb_we_o      (wb_we_o),
        .wb_fault_o   (wb_fault_o)
    );

endmodule

// File: load_extract_stage.sv
`timescale 1ns/10ps

module load_extract_stage import mem_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    wb_stage_if.sink              wb,
    output logic                  wb_valid_o,
    output logic [TAG_W-1:0]      wb_tag_o,
    output logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic [DATA_W-1:0]     wb_data_o,
    output logic                  wb_we_o,
    output logic                  wb_fault_o
);

    logic [DATA_W-1:0] shifted;
    logic [DATA_W-1:0] result;

    // addressed byte or halfword moved down to bit 0
    assign shifted = wb.rdata >> {wb.word.addr.byte_off, 3'b000};

    always_comb begin
        case (wb.op)
            MEM_LB: begin
                result = {{24{shifted[7]}}, shifted[7:0]};
            end
            MEM_LBU: begin
                result = {24'b0, shifted[7:0]};
            end
            MEM_LH: begin
                result = {{16{shifted[15]}}, shifted[15:0]};
            end
            MEM_LHU: begin
                result = {16'b0, shifted[15:0]};
            end
            MEM_LW: begin
                result = wb.rdata;
            end
            default: begin
                result = wb.word.data;    // alu result passes through
            end
        endcase
        if (wb.fault) begin
            result = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
            wb_fault_o <= 1'b0;
        end else begin
            wb_valid_o <= wb.valid;
            wb_we_o    <= wb.valid && !wb.fault && !is_store(wb.op);
            wb_fault_o <= wb.valid && wb.fault;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_tag_o     <= wb.tag;
        wb_rd_addr_o <= wb.rd_addr;
        wb_data_o    <= result;
    end

endmodule

// File: data_bus_unit.sv
`timescale 1ns/10ps

module data_bus_unit import mem_pkg::*; (
    input  logic              clk_i,
    input  logic              rstn_i,
    mem_bus_if.completer      bus,
    output logic              dmem_req_o,
    output logic              dmem_we_o,
    output logic [ADDR_W-1:0] dmem_addr_o,
    output logic [BE_W-1:0]   dmem_be_o,
    output logic [DATA_W-1:0] dmem_wdata_o,
    input  logic              dmem_ack_i,
    input  logic [DATA_W-1:0] dmem_rdata_i
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;    // req high, waiting for ack
    localparam logic [1:0] ST_REL  = 2'd2;    // req dropped, waiting for ack low
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0]        state_q;
    logic [DATA_W-1:0] rdata_q;
    logic              start;
    logic              ack_seen;

    // no new req while memory still holds ack
    assign start    = (state_q == ST_IDLE) && bus.req && !dmem_ack_i;
    assign ack_seen = (state_q == ST_REQ) && dmem_ack_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q    <= ST_IDLE;
            dmem_req_o <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        dmem_req_o <= 1'b1;
                        state_q    <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (ack_seen) begin
                        dmem_req_o <= 1'b0;
                        state_q    <= ST_REL;
                    end
                end
                ST_REL: begin
                    if (!dmem_ack_i) begin
                        state_q <= ST_DONE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;    // done lasts one cycle
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            dmem_we_o    <= bus.we;
            dmem_addr_o  <= bus.word_idx;
            dmem_be_o    <= bus.be;
            dmem_wdata_o <= bus.wdata;
        end
        if (ack_seen) begin
            rdata_q <= dmem_rdata_i;
        end
    end

    assign bus.done  = (state_q == ST_DONE);
    assign bus.rdata = rdata_q;

    // port copy still matches the held request
    a_port_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        dmem_req_o |-> {dmem_we_o, dmem_addr_o, dmem_be_o, dmem_wdata_o} ==
                       {bus.we, bus.word_idx, bus.be, bus.wdata});

endmodule

// File: mem_access_stage.sv
`timescale 1ns/10ps

module mem_access_stage import mem_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  uop_valid_i,
    input  logic [TAG_W-1:0]      uop_tag_i,
    input  logic [REG_ADDR_W-1:0] uop_rd_addr_i,
    input  mem_op_e               uop_op_i,
    input  mem_word_u             uop_word_i,
    input  logic [DATA_W-1:0]     uop_wdata_i,
    output logic                  stall_o,
    mem_bus_if.requester          bus,
    wb_stage_if.source            wb
);

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_WAIT = 1'b1;    // request out, waiting for done

    logic                  state_q;
    logic                  slot_valid_q;
    logic [TAG_W-1:0]      slot_tag_q;
    logic [REG_ADDR_W-1:0] slot_rd_q;
    mem_op_e               slot_op_q;
    mem_word_u             slot_word_q;
    logic [DATA_W-1:0]     slot_wdata_q;

    logic [BE_W-1:0]       al_be;
    logic [DATA_W-1:0]     al_wdata;
    logic                  misaligned;
    logic                  bus_op;
    logic                  accept;
    logic                  move;

    store_align u_align (
        .op_i         (slot_op_q),
        .byte_off_i   (slot_word_q.addr.byte_off),
        .wdata_i      (slot_wdata_q),
        .be_o         (al_be),
        .wdata_o      (al_wdata),
        .misaligned_o (misaligned)
    );

    assign bus_op  = slot_valid_q && is_mem(slot_op_q) && !misaligned;
    assign stall_o = bus_op;    // up to and including the done cycle
    assign accept  = uop_valid_i && !stall_o;
    // non-bus ops leave after one cycle
    assign move    = slot_valid_q && (!bus_op || (state_q == ST_WAIT && bus.done));

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q      <= ST_IDLE;
            slot_valid_q <= 1'b0;
        end else begin
            if (state_q == ST_IDLE && bus_op) begin
                state_q <= ST_WAIT;
            end else if (state_q == ST_WAIT && bus.done) begin
                state_q <= ST_IDLE;
            end
            if (accept) begin
                slot_valid_q <= 1'b1;
            end else if (move) begin
                slot_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            slot_tag_q   <= uop_tag_i;
            slot_rd_q    <= uop_rd_addr_i;
            slot_op_q    <= uop_op_i;
            slot_word_q  <= uop_word_i;
            slot_wdata_q <= uop_wdata_i;
        end
    end

    // slot is stable while waiting, so the request is too
    assign bus.req      = (state_q == ST_WAIT);
    assign bus.we       = is_store(slot_op_q);
    assign bus.word_idx = slot_word_q.addr.word_idx;
    assign bus.be       = al_be;
    assign bus.wdata    = al_wdata;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= move;
        end
    end

    always_ff @(posedge clk_i) begin
        if (move) begin
            wb.tag     <= slot_tag_q;
            wb.rd_addr <= slot_rd_q;
            wb.op      <= slot_op_q;
            wb.word    <= slot_word_q;
            wb.rdata   <= bus.rdata;
            wb.fault   <= misaligned;
        end
    end

    // request and payload held until done
    a_req_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bus.req && !bus.done |=> bus.req &&
            $stable({bus.we, bus.word_idx, bus.be, bus.wdata}));

    // completion only for an open request
    a_done_with_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bus.done |-> bus.req);

endmodule

// File: store_align.sv
`timescale 1ns/10ps

module store_align import mem_pkg::*; (
    input  mem_op_e           op_i,
    input  logic [1:0]        byte_off_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [BE_W-1:0]   be_o,
    output logic [DATA_W-1:0] wdata_o,
    output logic              misaligned_o
);

    always_comb begin
        be_o         = '0;
        wdata_o      = wdata_i;
        misaligned_o = 1'b0;
        case (op_i)
            MEM_SB: begin
                be_o    = BE_W'(1) << byte_off_i;
                wdata_o = {4{wdata_i[7:0]}};      // byte copied to every lane
            end
            MEM_SH: begin
                be_o         = byte_off_i[1] ? 4'b1100 : 4'b0011;
                wdata_o      = {2{wdata_i[15:0]}};
                misaligned_o = byte_off_i[0];
            end
            MEM_SW: begin
                be_o         = '1;
                misaligned_o = (byte_off_i != 2'b00);
            end
            MEM_LH, MEM_LHU: begin
                be_o         = '1;
                misaligned_o = byte_off_i[0];
            end
            MEM_LW: begin
                be_o         = '1;
                misaligned_o = (byte_off_i != 2'b00);
            end
            MEM_LB, MEM_LBU: begin
                be_o = '1;                        // byte loads never fault
            end
            default: begin
                be_o = '0;                        // ordinary op, no access
            end
        endcase
    end

endmodule

// File: wb_stage_if.sv
`timescale 1ns/10ps

interface wb_stage_if import mem_pkg::*; #(
    parameter int TAG_W = 4
) ();

    logic                  valid;
    logic [TAG_W-1:0]      tag;
    logic [REG_ADDR_W-1:0] rd_addr;
    mem_op_e               op;
    mem_word_u             word;
    logic [DATA_W-1:0]     rdata;     // raw bus word, loads only
    logic                  fault;     // misaligned access

    modport source (output valid, tag, rd_addr, op, word, rdata, fault);

    modport sink   (input  valid, tag, rd_addr, op, word, rdata, fault);

endinterface

// File: mem_bus_if.sv
`timescale 1ns/10ps

interface mem_bus_if import mem_pkg::*; ();

    logic              req;        // level, held until done
    logic              we;
    logic [ADDR_W-1:0] word_idx;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
    logic              done;       // single cycle
    logic [DATA_W-1:0] rdata;      // valid with done

    // access stage side
    modport requester (
        output req, we, word_idx, be, wdata,
        input  done, rdata
    );

    // bus unit side
    modport completer (
        input  req, we, word_idx, be, wdata,
        output done, rdata
    );

endinterface

// File: mem_pkg.sv
package mem_pkg;

    localparam int DATA_W     = 32;
    localparam int BE_W       = DATA_W / 8;
    localparam int ADDR_W     = DATA_W - 2;    // word index width on the port
    localparam int REG_ADDR_W = 5;

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,    // ordinary op, word holds the alu result
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // main word of a micro-op
    // data view for results, addr view for loads and stores
    typedef union packed {
        logic [DATA_W-1:0] data;
        struct packed {
            logic [ADDR_W-1:0] word_idx;
            logic [1:0]        byte_off;
        } addr;
    } mem_word_u;

    function automatic logic is_load(input mem_op_e op);
        logic res;
        res = (op == MEM_LB) || (op == MEM_LH) || (op == MEM_LW) ||
              (op == MEM_LBU) || (op == MEM_LHU);
        return res;
    endfunction

    function automatic logic is_store(input mem_op_e op);
        logic res;
        res = (op == MEM_SB) || (op == MEM_SH) || (op == MEM_SW);
        return res;
    endfunction

    // anything that needs the data bus
    function automatic logic is_mem(input mem_op_e op);
        logic res;
        res = is_load(op) || is_store(op);
        return res;
    endfunction

endpackage
